// File: rtl/exec_pkg.sv
/*
 * execute stage package: word, condition code and shift types, opcodes
 */
package exec_pkg;

   typedef logic [15:0] word_t;

   // ordered n, z, v, c from the top bit down
   typedef logic [3:0] cc_t;

   // signed ash count, negative shifts right
   typedef logic signed [5:0] shift_count_t;

   typedef enum logic [1:0]
   {
      idle,
      shifting,
      done
   } ash_state_t;

   // isn[15:9]
   localparam logic [6:0] op_ash = 7'o072;
   localparam logic [6:0] op_xor = 7'o074;

   // double operand, isn[15:12]
   localparam logic [3:0] op_mov = 4'o01;
   localparam logic [3:0] op_cmp = 4'o02;
   localparam logic [3:0] op_bit = 4'o03;
   localparam logic [3:0] op_bic = 4'o04;
   localparam logic [3:0] op_bis = 4'o05;
   localparam logic [3:0] op_add = 4'o06;
   localparam logic [3:0] op_sub = 4'o16;

   // single operand, isn[11:6] with isn[15:12] zero
   localparam logic [5:0] op_swab = 6'o03;
   localparam logic [5:0] op_clr  = 6'o50;
   localparam logic [5:0] op_com  = 6'o51;
   localparam logic [5:0] op_inc  = 6'o52;
   localparam logic [5:0] op_dec  = 6'o53;
   localparam logic [5:0] op_neg  = 6'o54;
   localparam logic [5:0] op_adc  = 6'o55;
   localparam logic [5:0] op_sbc  = 6'o56;
   localparam logic [5:0] op_tst  = 6'o57;
   localparam logic [5:0] op_ror  = 6'o60;
   localparam logic [5:0] op_rol  = 6'o61;
   localparam logic [5:0] op_asr  = 6'o62;
   localparam logic [5:0] op_asl  = 6'o63;

endpackage

// File: rtl/word_alu.sv
/*
 * word alu: single cycle double and single operand operations with n, z, v, c
 */
`timescale 1ns/1ns

module word_alu
   import exec_pkg::*;
(
   input  word_t isn,
   input  word_t ss_data,
   input  word_t dd_data,
   input  cc_t   cc_in,
   output logic  alu_hit,
   output word_t alu_result,
   output cc_t   alu_cc
);

   word_t res;
   logic  v;
   logic  c;
   logic  n;
   logic  z;
   logic  shift_v;

   always_comb
   begin
      alu_hit = 1'b1;
      res = '0;
      v = 1'b0;
      c = cc_in[0];
      shift_v = 1'b0;
      if (isn[15:9] == op_xor)
         res = ss_data ^ dd_data;
      else if (isn[15:12] == 4'o00)
      begin
         case (isn[11:6])
            op_swab:
            begin
               res = {dd_data[7:0], dd_data[15:8]};
               c = 1'b0;
            end
            op_clr:
               c = 1'b0;
            op_com:
            begin
               res = ~dd_data;
               c = 1'b1;
            end
            op_inc:
            begin
               res = dd_data + 16'd1;
               v = (res == 16'o100000);
            end
            op_dec:
            begin
               res = dd_data - 16'd1;
               v = (res == 16'o077777);
            end
            op_neg:
            begin
               res = -dd_data;
               v = (res == 16'o100000);
               c = (res != 16'd0);
            end
            op_adc:
            begin
               res = dd_data + {15'd0, cc_in[0]};
               v = cc_in[0] && (res == 16'o100000);
               c = cc_in[0] && (res == 16'd0);
            end
            op_sbc:
            begin
               res = dd_data - {15'd0, cc_in[0]};
               v = cc_in[0] && (res == 16'o077777);
               c = cc_in[0] && (res == 16'o177777);
            end
            op_tst:
            begin
               res = dd_data;
               c = 1'b0;
            end
            op_ror:
            begin
               res = {cc_in[0], dd_data[15:1]};
               c = dd_data[0];
               shift_v = 1'b1;
            end
            op_rol:
            begin
               res = {dd_data[14:0], cc_in[0]};
               c = dd_data[15];
               shift_v = 1'b1;
            end
            op_asr:
            begin
               res = {dd_data[15], dd_data[15:1]};
               c = dd_data[0];
               shift_v = 1'b1;
            end
            op_asl:
            begin
               res = {dd_data[14:0], 1'b0};
               c = dd_data[15];
               shift_v = 1'b1;
            end
            default:
               alu_hit = 1'b0;
         endcase
      end
      else
      begin
         case (isn[15:12])
            op_mov: res = ss_data;
            op_bit: res = ss_data & dd_data;
            op_bic: res = ~ss_data & dd_data;
            op_bis: res = ss_data | dd_data;
            op_cmp:
            begin
               res = ss_data - dd_data;
               v = (ss_data[15] ^ dd_data[15]) & (~dd_data[15] ^ res[15]);
               c = ss_data < dd_data;
            end
            op_add:
            begin
               res = ss_data + dd_data;
               v = (~ss_data[15] ^ dd_data[15]) & (ss_data[15] ^ res[15]);
               c = res < ss_data;
            end
            op_sub:
            begin
               res = dd_data - ss_data;
               v = (ss_data[15] ^ dd_data[15]) & (~ss_data[15] ^ res[15]);
               c = dd_data < ss_data;
            end
            default:
               alu_hit = 1'b0;
         endcase
      end

      // swab flags come from the low byte
      if (isn[15:12] == 4'o00 && isn[11:6] == op_swab)
      begin
         n = res[7];
         z = (res[7:0] == 8'd0);
      end
      else
      begin
         n = res[15];
         z = (res == 16'd0);
      end
      if (shift_v)
         v = n ^ c;
   end

   assign alu_result = alu_hit ? res : '0;
   assign alu_cc = alu_hit ? {n, z, v, c} : '0;

   // mul, div, ash, ashc and sob belong to other units
   always_comb
   begin
      if (isn[15:12] == 4'o07 && isn[15:9] != op_xor)
         assert (!alu_hit) else $error("alu claimed 07xxxx isn %o", isn);
   end

endmodule

// File: rtl/branch_unit.sv
/*
 * branch unit: decodes the fifteen branches, tests the codes, forms the target
 */
`timescale 1ns/1ns

module branch_unit
   import exec_pkg::*;
(
   input  word_t isn,
   input  word_t pc,
   input  cc_t   cc_in,
   output logic  br_hit,
   output logic  br_taken,
   output word_t br_target
);

   logic cn;
   logic cz;
   logic cv;
   logic cc;
   logic cond;

   assign {cn, cz, cv, cc} = cc_in;

   // 0004xx..0037xx and 1000xx..1037xx
   assign br_hit = (isn[14:11] == 4'd0) && (isn[15] || isn[10:8] != 3'd0);

   always_comb
   begin
      case ({isn[15], isn[10:8]})
         4'o01: cond = 1'b1;
         4'o02: cond = ~cz;
         4'o03: cond = cz;
         4'o04: cond = ~(cn ^ cv);
         4'o05: cond = cn ^ cv;
         4'o06: cond = ~(cz | (cn ^ cv));
         4'o07: cond = cz | (cn ^ cv);
         4'o10: cond = ~cn;
         4'o11: cond = cn;
         4'o12: cond = ~(cc | cz);
         4'o13: cond = cc | cz;
         4'o14: cond = ~cv;
         4'o15: cond = cv;
         4'o16: cond = ~cc;
         4'o17: cond = cc;
         default: cond = 1'b0;
      endcase
   end

   assign br_taken = br_hit & cond;
   // word offset, sign extended
   assign br_target = br_hit ? pc + {{7{isn[7]}}, isn[7:0], 1'b0} : '0;

endmodule

// File: rtl/ash_shifter.sv
/*
 * ash shifter: bit serial arithmetic shift, one position per clock
 */
`timescale 1ns/1ns

module ash_shifter
   import exec_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n,
   input  logic         shift_go,
   input  word_t        operand,
   input  shift_count_t count,
   output logic         shift_done,
   output word_t        shift_result,
   output cc_t          shift_cc
);

   ash_state_t state;
   logic [5:0] remaining;
   logic       left;
   word_t      acc;
   logic       last_out;
   logic       sign_change;
   logic [5:0] magnitude;

   assign magnitude = count[5] ? 6'(-count) : 6'(count);

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state <= idle;
         remaining <= '0;
      end
      else
      begin
         case (state)
            idle:
               if (shift_go)
               begin
                  remaining <= magnitude;
                  state <= (magnitude == 6'd0) ? done : shifting;
               end
            shifting:
               if (!shift_go)
                  state <= idle;
               else
               begin
                  remaining <= remaining - 6'd1;
                  if (remaining == 6'd1)
                     state <= done;
               end
            default:
               state <= idle;
         endcase
      end
   end

   // datapath
   always_ff @(posedge clk)
   begin
      if (state == idle)
      begin
         acc <= operand;
         left <= ~count[5];
         last_out <= 1'b0;
         sign_change <= 1'b0;
      end
      else if (state == shifting)
      begin
         if (left)
         begin
            acc <= {acc[14:0], 1'b0};
            last_out <= acc[15];
            sign_change <= sign_change | (acc[15] ^ acc[14]);
         end
         else
         begin
            acc <= {acc[15], acc[15:1]};
            last_out <= acc[0];
         end
      end
   end

   assign shift_done = (state == done);
   assign shift_result = shift_done ? acc : '0;
   assign shift_cc = shift_done ? {acc[15], acc == 16'd0, sign_change, last_out} : '0;

   // done only once the counter has run out
   assert property (@(posedge clk) disable iff (!arst_n)
      shift_done |-> remaining == 6'd0);

   // done must be entered before the counter wraps
   assert property (@(posedge clk) disable iff (!arst_n)
      state == shifting |-> remaining != 6'd0);

endmodule

// File: rtl/exec_control.sv
/*
 * execute control: starts ash, picks the result source, drives e1_advance
 */
`timescale 1ns/1ns

module exec_control
   import exec_pkg::*;
(
   input  logic  enable,
   input  word_t isn,
   input  logic  alu_hit,
   input  word_t alu_result,
   input  cc_t   alu_cc,
   input  logic  br_hit,
   input  logic  br_taken,
   input  word_t br_target,
   input  word_t shift_result,
   input  cc_t   shift_cc,
   input  logic  shift_done,
   input  cc_t   cc_in,
   output logic  shift_go,
   output word_t e1_result,
   output cc_t   new_cc,
   output logic  latch_cc,
   output word_t new_pc,
   output logic  latch_pc,
   output logic  e1_advance
);

   logic is_ash;

   assign is_ash = (isn[15:9] == op_ash);
   assign shift_go = enable & is_ash;

   always_comb
   begin
      e1_result = '0;
      new_cc = '0;
      latch_cc = 1'b0;
      new_pc = '0;
      latch_pc = 1'b0;
      e1_advance = 1'b0;
      if (enable)
      begin
         e1_advance = 1'b1;
         if (is_ash)
         begin
            e1_result = shift_result;
            new_cc = shift_cc;
            latch_cc = 1'b1;
            e1_advance = shift_done;
         end
         else if (alu_hit)
         begin
            e1_result = alu_result;
            new_cc = alu_cc;
            latch_cc = 1'b1;
         end
         else if (br_hit)
         begin
            // codes pass through unchanged
            new_cc = cc_in;
            new_pc = br_target;
            latch_pc = br_taken;
         end
      end
   end

   // alu and branch decoders cover disjoint ranges
   always_comb
   begin
      assert (!(alu_hit && br_hit)) else $error("alu and branch both hit %o", isn);
   end

endmodule

// File: rtl/execute_unit.sv
/*
 * PDP-11 execute stage top: alu, branch unit, ash shifter and control
 */
`timescale 1ns/1ns

module execute_unit
   import exec_pkg::*;
(
   input  logic  clk,
   input  logic  arst_n,
   input  logic  enable,
   input  word_t isn,
   input  word_t pc,
   input  word_t ss_data,
   input  word_t dd_data,
   input  cc_t   cc_in,
   output word_t e1_result,
   output cc_t   new_cc,
   output logic  latch_cc,
   output word_t new_pc,
   output logic  latch_pc,
   output logic  e1_advance
);

   logic  alu_hit;
   word_t alu_result;
   cc_t   alu_cc;
   logic  br_hit;
   logic  br_taken;
   word_t br_target;
   logic  shift_go;
   logic  shift_done;
   word_t shift_result;
   cc_t   shift_cc;

   word_alu alu0 (.isn, .ss_data, .dd_data, .cc_in, .alu_hit, .alu_result, .alu_cc);

   branch_unit br0 (.isn, .pc, .cc_in, .br_hit, .br_taken, .br_target);

   ash_shifter ash0 (.clk, .arst_n, .shift_go, .operand(dd_data),
                     .count(shift_count_t'(dd_data[5:0])),
                     .shift_done, .shift_result, .shift_cc);

   exec_control ctl0 (.enable, .isn, .alu_hit, .alu_result, .alu_cc,
                      .br_hit, .br_taken, .br_target,
                      .shift_result, .shift_cc, .shift_done, .cc_in,
                      .shift_go, .e1_result, .new_cc, .latch_cc,
                      .new_pc, .latch_pc, .e1_advance);

endmodule

// File: include/exec_model.svh
/*
 * reference model of the execute stage for alu, branch and ash checks
 */
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

function automatic void model_alu(input word_t isn, input word_t ss, input word_t dd,
                                  input cc_t cc, output word_t r, output cc_t cco);
   logic [16:0] wide;
   int          sum;
   logic        n;
   logic        z;
   logic        v;
   logic        c;
   logic        shift;
   logic        low_byte;
   r = '0;
   wide = '0;
   sum = 0;
   v = 1'b0;
   c = cc[0];
   shift = 1'b0;
   low_byte = 1'b0;
   if (isn[15:9] == op_xor)
      r = ss ^ dd;
   else if (isn[15:12] == 4'o00)
   begin
      case (isn[11:6])
         op_swab:
         begin
            r = {dd[7:0], dd[15:8]};
            c = 1'b0;
            low_byte = 1'b1;
         end
         op_clr:
            c = 1'b0;
         op_com:
         begin
            r = ~dd;
            c = 1'b1;
         end
         op_inc:
         begin
            r = dd + 16'd1;
            v = (dd == 16'o077777);
         end
         op_dec:
         begin
            r = dd - 16'd1;
            v = (dd == 16'o100000);
         end
         op_neg:
         begin
            r = 16'd0 - dd;
            v = (dd == 16'o100000);
            c = (dd != 16'd0);
         end
         op_adc:
         begin
            r = dd + {15'd0, cc[0]};
            v = cc[0] && dd == 16'o077777;
            c = cc[0] && dd == 16'o177777;
         end
         op_sbc:
         begin
            r = dd - {15'd0, cc[0]};
            v = cc[0] && dd == 16'o100000;
            c = cc[0] && dd == 16'd0;
         end
         op_tst:
         begin
            r = dd;
            c = 1'b0;
         end
         // rotate and shift through a 17 bit view of c and the word
         op_ror:
         begin
            {r, c} = {cc[0], dd};
            shift = 1'b1;
         end
         op_rol:
         begin
            {c, r} = {dd, cc[0]};
            shift = 1'b1;
         end
         op_asr:
         begin
            {r, c} = {dd[15], dd};
            shift = 1'b1;
         end
         default:
         begin
            {c, r} = {dd, 1'b0};
            shift = 1'b1;
         end
      endcase
   end
   else
   begin
      // overflow when the signed result leaves the word range
      case (isn[15:12])
         op_mov: r = ss;
         op_bit: r = ss & dd;
         op_bic: r = ~ss & dd;
         op_bis: r = ss | dd;
         op_cmp:
         begin
            wide = {1'b0, ss} - {1'b0, dd};
            sum = int'($signed(ss)) - int'($signed(dd));
         end
         op_add:
         begin
            wide = {1'b0, ss} + {1'b0, dd};
            sum = int'($signed(ss)) + int'($signed(dd));
         end
         default:
         begin
            wide = {1'b0, dd} - {1'b0, ss};
            sum = int'($signed(dd)) - int'($signed(ss));
         end
      endcase
      if (isn[15:12] == op_cmp || isn[15:12] == op_add || isn[15:12] == op_sub)
      begin
         r = wide[15:0];
         c = wide[16];
         v = (sum < -32768 || sum > 32767);
      end
   end
   if (low_byte)
   begin
      n = r[7];
      z = (r[7:0] == 8'd0);
   end
   else
   begin
      n = r[15];
      z = (r == 16'd0);
   end
   if (shift)
      v = n ^ c;
   cco = {n, z, v, c};
endfunction

function automatic void model_branch(input word_t isn, input word_t pc, input cc_t cc,
                                     output logic taken, output word_t target);
   logic n;
   logic z;
   logic v;
   logic c;
   {n, z, v, c} = cc;
   target = pc + word_t'(2 * int'($signed(isn[7:0])));
   case ({isn[15], isn[10:8]})
      4'o01: taken = 1;
      4'o02: taken = !z;
      4'o03: taken = z;
      4'o04: taken = !(n ^ v);
      4'o05: taken = n ^ v;
      4'o06: taken = !(z || (n ^ v));
      4'o07: taken = z || (n ^ v);
      4'o10: taken = !n;
      4'o11: taken = n;
      4'o12: taken = !(c || z);
      4'o13: taken = c || z;
      4'o14: taken = !v;
      4'o15: taken = v;
      4'o16: taken = !c;
      default: taken = c;
   endcase
endfunction

// one bit per step, as the hardware does
function automatic void model_ash(input word_t dd, output word_t r, output cc_t cco);
   int   cnt;
   logic c;
   logic v;
   cnt = int'(shift_count_t'(dd[5:0]));
   r = dd;
   c = 0;
   v = 0;
   for (int i = 0; i < (cnt < 0 ? -cnt : cnt); i++)
   begin
      if (cnt > 0)
      begin
         c = r[15];
         r = {r[14:0], 1'b0};
         // any step that leaves the original sign
         if (r[15] != dd[15])
            v = 1'b1;
      end
      else
      begin
         c = r[0];
         r = {r[15], r[15:1]};
      end
   end
   cco = {r[15], r == 16'd0, v, c};
endfunction

`endif

// File: bench/execute_tb.sv
/*
 * execute stage testbench: random alu, branch and ash operations vs a model
 */
`timescale 1ns/1ns

module execute_tb
   import exec_pkg::*;
();

   `include "exec_model.svh"

   localparam int clk_period = 8;
   localparam int max_ops = 400;
   localparam int cycles_per_op = 40;

   localparam logic [3:0] double_ops [7] = '{op_mov, op_cmp, op_bit, op_bic, op_bis,
                                             op_add, op_sub};
   localparam logic [5:0] single_ops [13] = '{op_swab, op_clr, op_com, op_inc, op_dec,
                                              op_neg, op_adc, op_sbc, op_tst, op_ror,
                                              op_rol, op_asr, op_asl};
   localparam word_t edge_values [4] = '{16'o077777, 16'o100000, 16'o177777, 16'o000000};

   logic  clk;
   logic  arst_n;
   logic  enable;
   word_t isn;
   word_t pc;
   word_t ss_data;
   word_t dd_data;
   cc_t   cc_in;
   word_t e1_result;
   cc_t   new_cc;
   logic  latch_cc;
   word_t new_pc;
   logic  latch_pc;
   logic  e1_advance;

   logic [15:0] lfsr;
   int          op_count;

   execute_unit dut0 (.clk, .arst_n, .enable, .isn, .pc, .ss_data, .dd_data, .cc_in,
                      .e1_result, .new_cc, .latch_cc, .new_pc, .latch_pc, .e1_advance);

   initial
   begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   initial
   begin
      #(max_ops * cycles_per_op * clk_period);
      fail_run("watchdog expired before all operations completed");
   end

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("Test failures found");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (exp !== act)
         fail_run($sformatf("Mismatch %s expected %06o actual %06o", name, exp, act));
   endtask

   task automatic check_cc(input string name, input cc_t exp, input cc_t act);
      if (exp !== act)
         fail_run($sformatf("Mismatch %s expected nzvc %b actual nzvc %b", name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act)
         fail_run($sformatf("Mismatch %s expected %b actual %b", name, exp, act));
   endtask

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] galois_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v = {v[30:0], lfsr[0]};
         lfsr = galois_step(lfsr);
      end
      return v;
   endfunction

   task automatic check_idle(input string name);
      check_bit({name, " e1_advance"}, 1'b0, e1_advance);
      check_bit({name, " latch_pc"}, 1'b0, latch_pc);
      check_bit({name, " latch_cc"}, 1'b0, latch_cc);
   endtask

   // drive one operation and wait until e1_advance is seen before an edge
   task automatic issue_op(input word_t i, input word_t s, input word_t d, input word_t p,
                           input cc_t c, output int waited);
      isn = i;
      ss_data = s;
      dd_data = d;
      pc = p;
      cc_in = c;
      enable = 1'b1;
      waited = 0;
      op_count++;
      @(negedge clk);
      while (!e1_advance && waited < cycles_per_op)
      begin
         waited++;
         @(negedge clk);
      end
      if (!e1_advance)
         fail_run($sformatf("no e1_advance for isn %06o within %0d cycles", i, cycles_per_op));
   endtask

   // completing edge, then one cycle with enable low
   task automatic retire_op();
      @(posedge clk);
      #1;
      enable = 1'b0;
      @(negedge clk);
      check_idle("enable low");
      @(posedge clk);
      #1;
   endtask

   task automatic run_double();
      int          sel;
      int          waited;
      logic [11:0] low;
      word_t       i;
      word_t       s;
      word_t       d;
      word_t       r;
      cc_t         c;
      cc_t         cc_exp;
      string       name;
      sel = int'(take_bits(3));
      low = 12'(take_bits(12));
      i = (sel == 7) ? {op_xor, low[8:0]} : {double_ops[sel], low};
      s = word_t'(take_bits(16));
      d = word_t'(take_bits(16));
      c = cc_t'(take_bits(4));
      name = $sformatf("double isn %06o", i);
      issue_op(i, s, d, word_t'(take_bits(16)), c, waited);
      model_alu(i, s, d, c, r, cc_exp);
      check_bit({name, " single cycle"}, 1'b1, waited == 0);
      check_word({name, " result"}, r, e1_result);
      check_cc({name, " cc"}, cc_exp, new_cc);
      check_bit({name, " latch_cc"}, 1'b1, latch_cc);
      check_bit({name, " latch_pc"}, 1'b0, latch_pc);
      // mov and logical operations keep c
      if (sel == 0 || sel == 2 || sel == 3 || sel == 4 || sel == 7)
         check_bit({name, " c kept"}, c[0], new_cc[0]);
      retire_op();
   endtask

   task automatic run_single(input logic [5:0] op, input word_t d, input cc_t c);
      int    waited;
      word_t i;
      word_t r;
      cc_t   cc_exp;
      string name;
      i = {4'o00, op, 6'(take_bits(6))};
      name = $sformatf("single isn %06o dd %06o", i, d);
      issue_op(i, word_t'(take_bits(16)), d, word_t'(take_bits(16)), c, waited);
      model_alu(i, ss_data, d, c, r, cc_exp);
      check_bit({name, " single cycle"}, 1'b1, waited == 0);
      check_word({name, " result"}, r, e1_result);
      check_cc({name, " cc"}, cc_exp, new_cc);
      check_bit({name, " latch_cc"}, 1'b1, latch_cc);
      check_bit({name, " latch_pc"}, 1'b0, latch_pc);
      retire_op();
   endtask

   task automatic run_branch();
      int         waited;
      logic [3:0] code;
      word_t      i;
      word_t      p;
      word_t      target;
      logic       taken;
      cc_t        c;
      string      name;
      code = 4'(take_bits(4) % 15 + 1);
      i = {code[3], 4'b0000, code[2:0], 8'(take_bits(8))};
      p = word_t'(take_bits(16));
      c = cc_t'(take_bits(4));
      name = $sformatf("branch isn %06o cc %b", i, c);
      issue_op(i, word_t'(take_bits(16)), word_t'(take_bits(16)), p, c, waited);
      model_branch(i, p, c, taken, target);
      check_bit({name, " single cycle"}, 1'b1, waited == 0);
      check_bit({name, " taken"}, taken, latch_pc);
      check_word({name, " target"}, target, new_pc);
      check_bit({name, " latch_cc"}, 1'b0, latch_cc);
      check_cc({name, " cc passed"}, c, new_cc);
      check_word({name, " result"}, 16'd0, e1_result);
      retire_op();
   endtask

   task automatic run_ash(input word_t d);
      int    waited;
      word_t i;
      word_t r;
      cc_t   cc_exp;
      string name;
      i = {op_ash, 9'(take_bits(9))};
      name = $sformatf("ash dd %06o", d);
      issue_op(i, word_t'(take_bits(16)), d, word_t'(take_bits(16)),
               cc_t'(take_bits(4)), waited);
      model_ash(d, r, cc_exp);
      check_word({name, " result"}, r, e1_result);
      check_cc({name, " cc"}, cc_exp, new_cc);
      check_bit({name, " latch_cc"}, 1'b1, latch_cc);
      check_bit({name, " latch_pc"}, 1'b0, latch_pc);
      retire_op();
   endtask

   initial
   begin
      lfsr = 16'd19;
      op_count = 0;
      arst_n = 1'b0;
      enable = 1'b0;
      isn = '0;
      pc = '0;
      ss_data = '0;
      dd_data = '0;
      cc_in = '0;
      repeat (3) @(posedge clk);
      #1;
      arst_n = 1'b1;
      @(negedge clk);
      check_idle("after reset");
      @(posedge clk);
      #1;

      repeat (100) run_double();

      // every single operand op on the edge words
      for (int k = 0; k < 13; k++)
         for (int e = 0; e < 4; e++)
            run_single(single_ops[k], edge_values[e], cc_t'(take_bits(4)));
      for (int e = 0; e < 4; e++)
      begin
         run_single(op_adc, edge_values[e], 4'b0001);
         run_single(op_sbc, edge_values[e], 4'b0001);
      end
      repeat (60) run_single(single_ops[take_bits(4) % 13], word_t'(take_bits(16)),
                             cc_t'(take_bits(4)));

      repeat (80) run_branch();

      // counts 0, 31, -32, 1 and -1
      run_ash({10'(take_bits(10)), 6'o00});
      run_ash({10'(take_bits(10)), 6'o37});
      run_ash({10'(take_bits(10)), 6'o40});
      run_ash({10'(take_bits(10)), 6'o01});
      run_ash({10'(take_bits(10)), 6'o77});
      repeat (70) run_ash(word_t'(take_bits(16)));

      $display("%0d operations checked", op_count);
      $display("All tests passed!");
      $finish;
   end

endmodule

// File: compile.f
+incdir+include
rtl/exec_pkg.sv
rtl/word_alu.sv
rtl/branch_unit.sv
rtl/ash_shifter.sv
rtl/exec_control.sv
rtl/execute_unit.sv
bench/execute_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module execute_tb \
   -f compile.f -o sim_execute > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "build failed, see build.log"
   exit 1
fi

./obj_dir/sim_execute > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Test failures found" sim.log; then
   echo "simulation reported failures"
   exit 1
fi
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi
echo "simulation passed"
exit 0
